// ==== design/fetch_pkg.sv ====
/*
 * Shared types and constants of the instruction fetch front end.
 * Every fetch stage refers to these by scoped name.
 * The structs describe what moves from one stage to the next.
 */

package fetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths with a meaning
    //////////////////////////////////////////////////////////////////////

    // byte address on the instruction bus
    typedef logic [31:0] addr_t;
    // one 32-bit RISC-V instruction word
    typedef logic [31:0] instr_t;

    //////////////////////////////////////////////////////////////////////
    // constants
    //////////////////////////////////////////////////////////////////////

    localparam addr_t  START_ADDRESS = 32'h0000_0000;
    // addi x0, x0, 0
    localparam instr_t NOP_INSTR     = 32'h0000_0013;
    // no compressed support, so the pc always steps one word
    localparam addr_t  INSTR_BYTES   = 32'd4;

    // prefetch ring size, must stay a power of two
    localparam int     BUF_DEPTH     = 4;
    localparam int     BUF_PTR_W     = $clog2(BUF_DEPTH);

    //////////////////////////////////////////////////////////////////////
    // stage to stage bundles
    //////////////////////////////////////////////////////////////////////

    // one fetched item with its pc
    typedef struct packed {
        logic   valid;
        addr_t  pc;
        instr_t instr;
    } fetch_word_t;

    // resolved redirect, ctx switch already wins over jump
    typedef struct packed {
        logic  taken;
        addr_t target;
    } redirect_t;

endpackage

// ==== design/fetch_addr_gen.sv ====
/*
 * Address stage of the fetch front end.
 * Owns the fetch address, picks the redirect target and holds the
 * address on memory busy or a nearly full prefetch buffer. Tags the
 * word coming back from memory with its pc and validity.
 */

`timescale 1ns/1ps

module fetch_addr_gen (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   enable_i,
    input  logic                   jump_i,
    input  logic                   ctx_switch_i,
    input  fetch_pkg::addr_t       jump_target_i,
    input  fetch_pkg::addr_t       ctx_switch_target_i,
    input  logic                   imem_busy_i,
    input  fetch_pkg::instr_t      imem_data_i,
    input  logic                   almost_full_i,
    output fetch_pkg::redirect_t   redirect_o,
    output fetch_pkg::addr_t       imem_addr_o,
    output fetch_pkg::fetch_word_t fetched_o
);

    //////////////////////////////////////////////////////////////////////
    // redirect selection
    //////////////////////////////////////////////////////////////////////

    // ctx switch has priority over jump
    always_comb begin
        redirect_o.taken = ctx_switch_i || jump_i;
        if (ctx_switch_i) begin
            redirect_o.target = ctx_switch_target_i;
        end else begin
            redirect_o.target = jump_target_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // fetch address
    //////////////////////////////////////////////////////////////////////

    fetch_pkg::addr_t addr_q;
    logic             hold;

    // memory busy, or buffer close to full with decode not taking
    assign hold = imem_busy_i || (almost_full_i && !enable_i);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            addr_q <= fetch_pkg::START_ADDRESS;
        end else if (redirect_o.taken) begin
            addr_q <= redirect_o.target;
        end else if (!hold) begin
            addr_q <= addr_q + fetch_pkg::INSTR_BYTES;
        end
    end

    // word aligned bus address
    assign imem_addr_o = {addr_q[31:2], 2'b00};

    //////////////////////////////////////////////////////////////////////
    // return tagging
    //////////////////////////////////////////////////////////////////////

    logic             accepted_q;
    fetch_pkg::addr_t req_pc_q;

    // address counts as taken only when it advanced this cycle
    // a redirect in the request cycle kills the old-stream word
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            accepted_q <= 1'b0;
        end else begin
            accepted_q <= !hold && !redirect_o.taken;
        end
    end

    always_ff @(posedge clk) begin
        req_pc_q <= imem_addr_o;
    end

    // redirect in the return cycle also kills it
    always_comb begin
        fetched_o.valid = accepted_q && !redirect_o.taken;
        fetched_o.pc    = req_pc_q;
        fetched_o.instr = imem_data_i;
    end

endmodule

// ==== design/fetch_prefetch_buf.sv ====
/*
 * Prefetch ring buffer between the address stage and the issue stage.
 * Stores returned words that decode does not take in the same cycle,
 * pops on enable and is flushed by every redirect. Presents the head
 * entry, or the returning word directly when the ring is empty.
 */

`timescale 1ns/1ps

module fetch_prefetch_buf (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   enable_i,
    input  fetch_pkg::redirect_t   redirect_i,
    input  fetch_pkg::fetch_word_t fetched_i,
    output fetch_pkg::fetch_word_t next_word_o,
    output logic                   almost_full_o
);

    //////////////////////////////////////////////////////////////////////
    // storage and pointers
    //////////////////////////////////////////////////////////////////////

    fetch_pkg::fetch_word_t         buf_mem [fetch_pkg::BUF_DEPTH];
    logic [fetch_pkg::BUF_PTR_W-1:0] wr_ptr_q;
    logic [fetch_pkg::BUF_PTR_W-1:0] rd_ptr_q;
    logic [fetch_pkg::BUF_PTR_W:0]   count_q;

    logic empty;
    logic push;
    logic pop;

    assign empty = (count_q == '0);

    // word bypasses the ring when empty and decode takes it now
    assign push = fetched_i.valid && !(empty && enable_i);
    assign pop  = enable_i && !empty;

    // one slot kept free for the word already in memory
    assign almost_full_o =
        (count_q >= (fetch_pkg::BUF_PTR_W+1)'(fetch_pkg::BUF_DEPTH - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (redirect_i.taken) begin
            // flush on any redirect
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // pointers wrap on their own, depth is a power of two
            count_q <= count_q + (fetch_pkg::BUF_PTR_W+1)'(push)
                               - (fetch_pkg::BUF_PTR_W+1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buf_mem[wr_ptr_q] <= fetched_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output selection
    //////////////////////////////////////////////////////////////////////

    // stale entries must not reach issue in the redirect cycle
    always_comb begin
        if (empty) begin
            next_word_o = fetched_i;
        end else begin
            next_word_o = buf_mem[rd_ptr_q];
        end
        next_word_o.valid = next_word_o.valid && !redirect_i.taken;
    end

endmodule

// ==== design/fetch_issue.sv ====
/*
 * Issue stage of the fetch front end.
 * Registers the instruction, pc and valid handed to decode on each
 * enabled cycle, and keeps the jumping flag that marks output from a
 * redirected stream. Starts from a NOP at the start address.
 */

`timescale 1ns/1ps

module fetch_issue (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   enable_i,
    input  fetch_pkg::redirect_t   redirect_i,
    input  fetch_pkg::fetch_word_t next_word_i,
    output logic                   valid_o,
    output fetch_pkg::addr_t       pc_o,
    output fetch_pkg::instr_t      instr_o,
    output logic                   jumping_o
);

    //////////////////////////////////////////////////////////////////////
    // decode outputs
    //////////////////////////////////////////////////////////////////////

    // valid follows every enabled cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o <= 1'b0;
        end else if (enable_i) begin
            valid_o <= next_word_i.valid;
        end
    end

    // instr and pc only move on a real word
    // so an empty cycle keeps the last one on the outputs
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_o    <= fetch_pkg::START_ADDRESS;
            instr_o <= fetch_pkg::NOP_INSTR;
        end else if (enable_i && next_word_i.valid) begin
            pc_o    <= next_word_i.pc;
            instr_o <= next_word_i.instr;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // jumping flag
    //////////////////////////////////////////////////////////////////////

    // high out of reset, reset is a redirect to the start address
    // set the cycle after a redirect
    // cleared by the first enabled cycle after that
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumping_o <= 1'b1;
        end else if (redirect_i.taken) begin
            jumping_o <= 1'b1;
        end else if (enable_i) begin
            jumping_o <= 1'b0;
        end
    end

endmodule

// ==== design/fetch_top.sv ====
/*
 * Top level of the instruction fetch front end.
 * Connects the address stage, the prefetch buffer and the issue stage
 * between the instruction memory port and the decode stage.
 */

`timescale 1ns/1ps

module fetch_top (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              enable_i,
    input  logic              jump_i,
    input  logic              ctx_switch_i,
    input  fetch_pkg::addr_t  jump_target_i,
    input  fetch_pkg::addr_t  ctx_switch_target_i,
    input  logic              imem_busy_i,
    input  fetch_pkg::instr_t imem_data_i,
    output fetch_pkg::addr_t  imem_addr_o,
    output logic              valid_o,
    output fetch_pkg::addr_t  pc_o,
    output fetch_pkg::instr_t instr_o,
    output logic              jumping_o
);

    // stage to stage nets
    fetch_pkg::redirect_t   redirect;
    fetch_pkg::fetch_word_t fetched;
    fetch_pkg::fetch_word_t next_word;
    logic                   almost_full;

    // address generation and return tagging
    fetch_addr_gen fetch_addr_gen_i (
        .clk                 (clk),
        .reset_n             (reset_n),
        .enable_i            (enable_i),
        .jump_i              (jump_i),
        .ctx_switch_i        (ctx_switch_i),
        .jump_target_i       (jump_target_i),
        .ctx_switch_target_i (ctx_switch_target_i),
        .imem_busy_i         (imem_busy_i),
        .imem_data_i         (imem_data_i),
        .almost_full_i       (almost_full),
        .redirect_o          (redirect),
        .imem_addr_o         (imem_addr_o),
        .fetched_o           (fetched)
    );

    // prefetch ring with bypass
    fetch_prefetch_buf fetch_prefetch_buf_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable_i      (enable_i),
        .redirect_i    (redirect),
        .fetched_i     (fetched),
        .next_word_o   (next_word),
        .almost_full_o (almost_full)
    );

    // decode facing registers
    fetch_issue fetch_issue_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .enable_i    (enable_i),
        .redirect_i  (redirect),
        .next_word_i (next_word),
        .valid_o     (valid_o),
        .pc_o        (pc_o),
        .instr_o     (instr_o),
        .jumping_o   (jumping_o)
    );

endmodule

// ==== verif/fetch_tb.sv ====
/*
 * Directed testbench for the fetch front end.
 * Memory is modelled as address xor a pattern with one cycle latency.
 * Every instruction handed to decode is checked against the pc stream
 * the front end has to follow through jumps, stalls and busy cycles.
 */

`timescale 1ns/1ps

module fetch_tb;

    // memory word of an address is the address xor this
    localparam fetch_pkg::instr_t MEM_PATTERN = 32'hA5C3_0F96;

    logic              clk;
    logic              reset_n;
    logic              enable_i;
    logic              jump_i;
    logic              ctx_switch_i;
    fetch_pkg::addr_t  jump_target_i;
    fetch_pkg::addr_t  ctx_switch_target_i;
    logic              imem_busy_i;
    fetch_pkg::instr_t imem_data_i = '0;
    fetch_pkg::addr_t  imem_addr_o;
    logic              valid_o;
    fetch_pkg::addr_t  pc_o;
    fetch_pkg::instr_t instr_o;
    logic              jumping_o;

    // scoreboard
    fetch_pkg::addr_t expected_pc;
    fetch_pkg::addr_t first_pc;
    logic             awaiting_first;
    int               out_count;
    int               err_count;
    int               check_count;
    int               test_count;
    int               test_err_start;

    fetch_top fetch_top_i (
        .clk(clk), .reset_n(reset_n), .enable_i(enable_i), .jump_i(jump_i),
        .ctx_switch_i(ctx_switch_i), .jump_target_i(jump_target_i),
        .ctx_switch_target_i(ctx_switch_target_i), .imem_busy_i(imem_busy_i),
        .imem_data_i(imem_data_i), .imem_addr_o(imem_addr_o), .valid_o(valid_o),
        .pc_o(pc_o), .instr_o(instr_o), .jumping_o(jumping_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // read takes one cycle, data line holds while busy
    always @(posedge clk) begin
        if (!imem_busy_i) begin
            imem_data_i <= imem_addr_o ^ MEM_PATTERN;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_addr(input string name, input fetch_pkg::addr_t got,
                              input fetch_pkg::addr_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_instr(input string name, input fetch_pkg::instr_t got,
                               input fetch_pkg::instr_t exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // cycle driver and scoreboard
    //////////////////////////////////////////////////////////////////////

    function automatic logic rand_bit();
        return 1'($urandom % 2);
    endfunction

    // pc must step by one word with no gap or repeat
    task automatic record_output();
        out_count++;
        check_addr("pc_o", pc_o, expected_pc);
        check_instr("instr_o", instr_o, expected_pc ^ MEM_PATTERN);
        if (awaiting_first) begin
            first_pc       = pc_o;
            awaiting_first = 1'b0;
        end
        // resync so a single slip is reported once
        expected_pc = pc_o + fetch_pkg::INSTR_BYTES;
    endtask

    // inputs seen by the dut are taken at the edge, outputs at the falling edge
    task automatic run_cycle(input logic en, input logic busy, input logic jmp,
                             input fetch_pkg::addr_t jt, input logic ctx,
                             input fetch_pkg::addr_t ct);
        logic             en_seen;
        logic             redirect_seen;
        fetch_pkg::addr_t target_seen;
        @(posedge clk);
        en_seen       = enable_i;
        redirect_seen = jump_i || ctx_switch_i;
        // context switch target wins over jump target
        target_seen   = ctx_switch_i ? ctx_switch_target_i : jump_target_i;
        enable_i            <= en;
        imem_busy_i         <= busy;
        jump_i              <= jmp;
        jump_target_i       <= jt;
        ctx_switch_target_i <= ct;
        ctx_switch_i        <= ctx;
        @(negedge clk);
        if (redirect_seen) begin
            expected_pc    = target_seen;
            awaiting_first = 1'b1;
            check_bit("jumping_o", jumping_o, 1'b1);
            // bus address moves to the target on the redirect edge
            check_addr("imem_addr_o", imem_addr_o, target_seen);
            if (en_seen) begin
                check_bit("valid_o", valid_o, 1'b0);
            end
        end else if (en_seen) begin
            check_bit("jumping_o", jumping_o, 1'b0);
            if (valid_o) begin
                record_output();
            end
        end
    endtask

    task automatic wait_outputs(input string name, input int n, input logic rand_en,
                                input logic rand_busy, input int max_cycles);
        int start;
        int cycles;
        start  = out_count;
        cycles = 0;
        while ((out_count - start) < n && cycles < max_cycles) begin
            run_cycle(rand_en ? rand_bit() : 1'b1, rand_busy ? rand_bit() : 1'b0,
                      1'b0, '0, 1'b0, '0);
            cycles++;
        end
        if ((out_count - start) < n) begin
            err_count++;
            $display("%s: only %0d of %0d instructions arrived within %0d cycles",
                     name, out_count - start, n, max_cycles);
        end
    endtask

    // runs until the first valid word after a redirect
    // the pulse driven last cycle is only seen at the next edge
    task automatic wait_first(input string name, input fetch_pkg::addr_t target,
                              input logic rand_busy, input int max_cycles);
        int cycles;
        cycles = 0;
        do begin
            run_cycle(1'b1, rand_busy ? rand_bit() : 1'b0, 1'b0, '0, 1'b0, '0);
            cycles++;
        end while (awaiting_first && cycles < max_cycles);
        if (awaiting_first) begin
            err_count++;
            $display("%s: no instruction after the redirect within %0d cycles",
                     name, max_cycles);
        end else begin
            check_addr("first pc_o", first_pc, target);
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (err_count == test_err_start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, err_count - test_err_start);
        end
        test_err_start = err_count;
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_values();
        @(negedge clk);
        check_bit("valid_o", valid_o, 1'b0);
        check_instr("instr_o", instr_o, fetch_pkg::NOP_INSTR);
        check_addr("pc_o", pc_o, fetch_pkg::START_ADDRESS);
        check_bit("jumping_o", jumping_o, 1'b1);
        end_test("reset_values");
    endtask

    task automatic sequential_fetch();
        wait_outputs("sequential_fetch", 24, 1'b0, 1'b0, 100);
        end_test("sequential_fetch");
    endtask

    task automatic jump_redirect();
        run_cycle(1'b1, 1'b0, 1'b1, 32'h0000_1000, 1'b0, '0);
        wait_first("jump_redirect", 32'h0000_1000, 1'b0, 50);
        wait_outputs("jump_redirect", 8, 1'b0, 1'b0, 40);
        end_test("jump_redirect");
    endtask

    // both pulses in one cycle
    task automatic ctx_switch_priority();
        run_cycle(1'b1, 1'b0, 1'b1, 32'h0000_3000, 1'b1, 32'h0000_2400);
        wait_first("ctx_switch_priority", 32'h0000_2400, 1'b0, 50);
        wait_outputs("ctx_switch_priority", 8, 1'b0, 1'b0, 40);
        end_test("ctx_switch_priority");
    endtask

    task automatic backpressure();
        int start;
        start = out_count;
        repeat (200) run_cycle(rand_bit(), 1'b0, 1'b0, '0, 1'b0, '0);
        if (out_count == start) begin
            err_count++;
            $display("backpressure: no instruction reached decode in 200 cycles");
        end
        end_test("backpressure");
    endtask

    // decode stalls first so the ring is full when the final jump hits
    // stale buffer entries must be dropped
    task automatic random_busy();
        wait_outputs("random_busy", 40, 1'b1, 1'b1, 400);
        repeat (6) run_cycle(1'b0, 1'b0, 1'b0, '0, 1'b0, '0);
        run_cycle(1'b1, rand_bit(), 1'b1, 32'h0000_4000, 1'b0, '0);
        wait_first("random_busy", 32'h0000_4000, 1'b1, 200);
        wait_outputs("random_busy", 8, 1'b0, 1'b1, 200);
        end_test("random_busy");
    endtask

    initial begin
        void'($urandom(66002));
        reset_n             = 1'b0;
        enable_i            = 1'b0;
        jump_i              = 1'b0;
        ctx_switch_i        = 1'b0;
        jump_target_i       = '0;
        ctx_switch_target_i = '0;
        imem_busy_i         = 1'b0;
        expected_pc         = fetch_pkg::START_ADDRESS;
        first_pc            = '0;
        awaiting_first      = 1'b0;
        out_count           = 0;
        err_count           = 0;
        check_count         = 0;
        test_count          = 0;
        test_err_start      = 0;
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        reset_values();
        sequential_fetch();
        jump_redirect();
        ctx_switch_priority();
        backpressure();
        random_busy();
        $display("tests %0d, checks %0d, instructions %0d, errors %0d",
                 test_count, check_count, out_count, err_count);
        if (err_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
design/fetch_pkg.sv
design/fetch_addr_gen.sv
design/fetch_prefetch_buf.sv
design/fetch_issue.sv
design/fetch_top.sv
verif/fetch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       ?= fetch_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
